//--- testbench/csr_vectors.txt
# test ex_we ex_waddr ex_wdata ex_raddr clint_we clint_waddr clint_wdata clint_raddr inst_valid
# exp_ex_rdata exp_clint_rdata exp_gie mask  (test in decimal, rest hex; mask bit0 ex, bit1 clint)
1 1 300 00001880 305 0 000 00000000 300 0 00000080 00000000 0 0
1 1 304 00000888 300 0 000 00000000 300 0 00001880 00001880 0 0
1 1 305 00001000 304 0 000 00000000 304 0 00000888 00000888 0 0
1 1 340 cafef00d 305 0 000 00000000 305 0 00001000 00001000 0 0
1 1 341 00002004 340 0 000 00000000 340 0 cafef00d cafef00d 0 0
1 1 342 8000000b 341 0 000 00000000 341 0 00002004 00002004 0 0
1 0 000 00000000 342 0 000 00000000 342 0 8000000b 8000000b 0 0
2 1 340 11111111 342 1 340 22222222 341 0 8000000b 00002004 0 0
2 1 341 33333333 340 1 342 44444444 340 0 11111111 11111111 0 0
2 0 000 00000000 341 0 000 00000000 342 0 33333333 44444444 0 0
3 1 340 55555555 340 0 000 00000000 340 0 55555555 11111111 0 0
3 0 000 00000000 304 1 304 00000aaa 304 0 00000888 00000aaa 0 0
3 0 000 00000000 340 0 000 00000000 304 0 55555555 00000aaa 0 0
4 0 000 00000000 b00 0 000 00000000 b80 0 0000000d 00000000 0 0
4 1 b00 fffffffd b00 0 000 00000000 b00 0 fffffffd 0000000e 0 0
4 0 000 00000000 b00 0 000 00000000 b80 0 fffffffd 00000000 0 0
4 0 000 00000000 b00 0 000 00000000 b80 0 fffffffe 00000000 0 0
4 0 000 00000000 b80 1 b80 00000007 b00 0 00000000 ffffffff 0 0
4 0 000 00000000 b00 0 000 00000000 b80 0 ffffffff 00000007 0 0
4 0 000 00000000 b00 0 000 00000000 b80 0 00000000 00000008 0 0
5 0 000 00000000 b02 0 000 00000000 b82 1 00000000 00000000 0 0
5 0 000 00000000 b02 0 000 00000000 b82 0 00000001 00000000 0 0
5 0 000 00000000 b02 0 000 00000000 b82 1 00000001 00000000 0 0
5 0 000 00000000 b02 1 b02 00000100 b82 1 00000002 00000000 0 0
5 0 000 00000000 b02 0 000 00000000 b82 1 00000100 00000000 0 0
5 0 000 00000000 b02 0 000 00000000 b00 0 00000101 00000006 0 0
6 1 300 00000008 301 0 000 00000000 7c0 0 40001100 00000000 0 0
6 0 000 00000000 300 0 000 00000000 300 0 00000008 00000008 1 0
6 0 000 00000000 f14 1 300 00001800 301 0 00000000 40001100 1 0
6 0 000 00000000 300 0 000 00000000 300 0 00001800 00001800 0 0
6 1 7c0 deadbeef 7c0 0 000 00000000 7c0 0 00000000 00000000 0 1
6 0 000 00000000 7c0 0 000 00000000 340 0 00000000 55555555 0 0

//--- sim.f
verilog/csr_pkg.sv
verilog/csr_port_if.sv
verilog/csr_write_arbiter.sv
verilog/csr_trap_regs.sv
verilog/csr_counters.sv
verilog/csr_read_mux.sv
verilog/csr_top.sv
testbench/csr_checker.sv
testbench/tb_csr.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the CSR testbench with Verilator, run it and scan the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module tb_csr \
    -f sim.f -o tb_csr_sim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/tb_csr_sim > "$LOG" 2>&1
cat "$LOG"

grep -q "TB FAILED" "$LOG" && { echo "simulation reported errors"; exit 1; }
grep -q "TB PASSED" "$LOG" || { echo "simulation ended without a result"; exit 1; }
echo "simulation clean"
exit 0

//--- testbench/tb_csr.sv
/*
 * Testbench for the machine-mode CSR block.
 * Reads stimulus and expected values from the vector file, applies
 * one vector per clock and lets csr_checker compare the responses.
 */
`timescale 1ns/100ps

module tb_csr;
    import csr_pkg::*;

    localparam int        CLK_PERIOD   = 10;
    localparam int        RESET_CYCLES = 5;
    localparam csr_word_t MISA_VALUE   = 32'h4000_1100;
    localparam csr_word_t MTVEC_RESET  = 32'h0000_0080;   // nonzero boot vector
    localparam string     VEC_FILE     = "testbench/csr_vectors.txt";

    typedef struct {
        int         test_id;
        logic       ex_we;
        csr_addr_t  ex_waddr;
        csr_word_t  ex_wdata;
        csr_addr_t  ex_raddr;
        logic       clint_we;
        csr_addr_t  clint_waddr;
        csr_word_t  clint_wdata;
        csr_addr_t  clint_raddr;
        logic       inst_valid;
        csr_word_t  exp_ex_rdata;
        csr_word_t  exp_clint_rdata;
        logic       exp_gie;
        logic [1:0] mask;
    } vector_t;

    vector_t    vecs[$];

    logic       clk;
    logic       reset;
    logic       ex_we;
    csr_addr_t  ex_waddr;
    csr_word_t  ex_wdata;
    csr_addr_t  ex_raddr;
    csr_word_t  ex_rdata;
    logic       clint_we;
    csr_addr_t  clint_waddr;
    csr_word_t  clint_wdata;
    csr_addr_t  clint_raddr;
    csr_word_t  clint_rdata;
    logic       inst_valid;
    logic       global_int_en;
    csr_word_t  clint_mtvec;
    csr_word_t  clint_mepc;
    csr_word_t  clint_mstatus;
    csr_word_t  clint_mie;

    logic       vec_valid;
    int         test_id;
    int         vec_idx;
    csr_word_t  exp_ex_rdata;
    csr_word_t  exp_clint_rdata;
    logic       exp_gie;
    logic [1:0] read_mask;
    logic       checks_done;
    int         error_count;
    int         check_count;
    int         cycle_count = 0;
    int         cycle_limit = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic load_vectors();
        int      fd;
        int      n;
        string   line;
        vector_t v;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s", VEC_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v.test_id, v.ex_we, v.ex_waddr, v.ex_wdata, v.ex_raddr,
                        v.clint_we, v.clint_waddr, v.clint_wdata, v.clint_raddr,
                        v.inst_valid, v.exp_ex_rdata, v.exp_clint_rdata, v.exp_gie, v.mask);
            if (n == 14) begin
                vecs.push_back(v); // comment and blank lines fall out here
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_vector(input vector_t v, input int idx);
        ex_we           <= v.ex_we;
        ex_waddr        <= v.ex_waddr;
        ex_wdata        <= v.ex_wdata;
        ex_raddr        <= v.ex_raddr;
        clint_we        <= v.clint_we;
        clint_waddr     <= v.clint_waddr;
        clint_wdata     <= v.clint_wdata;
        clint_raddr     <= v.clint_raddr;
        inst_valid      <= v.inst_valid;
        exp_ex_rdata    <= v.exp_ex_rdata;
        exp_clint_rdata <= v.exp_clint_rdata;
        exp_gie         <= v.exp_gie;
        read_mask       <= v.mask;
        test_id         <= v.test_id;
        vec_idx         <= idx;
        vec_valid       <= 1'b1;
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the vectors did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        ex_we           = 1'b0;
        ex_waddr        = '0;
        ex_wdata        = '0;
        ex_raddr        = '0;
        clint_we        = 1'b0;
        clint_waddr     = '0;
        clint_wdata     = '0;
        clint_raddr     = '0;
        inst_valid      = 1'b0;
        vec_valid       = 1'b0;
        test_id         = 0;
        vec_idx         = 0;
        exp_ex_rdata    = '0;
        exp_clint_rdata = '0;
        exp_gie         = 1'b0;
        read_mask       = '0;
        load_vectors();
        if (vecs.size() == 0) begin
            $display("no vectors could be read from %s", VEC_FILE);
            $display("TB FAILED");
            $finish;
        end else begin
            cycle_limit = 4 * vecs.size();
            repeat (RESET_CYCLES) @(posedge clk);
            reset <= 1'b0;
            // first vector goes in with reset release so mcycle reads 0 there
            for (int i = 0; i < vecs.size(); i++) begin
                apply_vector(vecs[i], i);
                @(posedge clk);
            end
            vec_valid <= 1'b0;
            while (!checks_done) @(posedge clk);
            $display("vectors %0d, checks %0d, errors %0d",
                     vecs.size(), check_count, error_count);
            if (error_count == 0 && check_count > 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

    csr_top #(
        .MISA_VALUE  (MISA_VALUE),
        .MTVEC_RESET (MTVEC_RESET)
    ) i_csr_top (
        .clk             (clk),
        .reset_i         (reset),
        .ex_we_i         (ex_we),
        .ex_waddr_i      (ex_waddr),
        .ex_wdata_i      (ex_wdata),
        .ex_raddr_i      (ex_raddr),
        .ex_rdata_o      (ex_rdata),
        .clint_we_i      (clint_we),
        .clint_waddr_i   (clint_waddr),
        .clint_wdata_i   (clint_wdata),
        .clint_raddr_i   (clint_raddr),
        .clint_rdata_o   (clint_rdata),
        .inst_valid_i    (inst_valid),
        .global_int_en_o (global_int_en),
        .clint_mtvec_o   (clint_mtvec),
        .clint_mepc_o    (clint_mepc),
        .clint_mstatus_o (clint_mstatus),
        .clint_mie_o     (clint_mie)
    );

    csr_checker i_csr_checker (
        .clk_i             (clk),
        .vec_valid_i       (vec_valid),
        .test_id_i         (test_id),
        .vec_idx_i         (vec_idx),
        .clint_we_i        (clint_we),
        .clint_waddr_i     (clint_waddr),
        .clint_raddr_i     (clint_raddr),
        .mask_i            (read_mask),
        .exp_ex_rdata_i    (exp_ex_rdata),
        .exp_clint_rdata_i (exp_clint_rdata),
        .exp_gie_i         (exp_gie),
        .ex_rdata_i        (ex_rdata),
        .clint_rdata_i     (clint_rdata),
        .global_int_en_i   (global_int_en),
        .clint_mtvec_i     (clint_mtvec),
        .clint_mepc_i      (clint_mepc),
        .clint_mstatus_i   (clint_mstatus),
        .clint_mie_i       (clint_mie),
        .done_o            (checks_done),
        .error_count_o     (error_count),
        .check_count_o     (check_count)
    );

endmodule

//--- testbench/csr_checker.sv
/*
 * CSR testbench checker.
 * Samples the DUT outputs at each rising edge, compares them with the
 * expected values of the vector in flight and prints one line per test.
 */
`timescale 1ns/100ps

module csr_checker (
    input  logic               clk_i,
    input  logic               vec_valid_i,
    input  int                 test_id_i,
    input  int                 vec_idx_i,
    input  logic               clint_we_i,
    input  csr_pkg::csr_addr_t clint_waddr_i,
    input  csr_pkg::csr_addr_t clint_raddr_i,
    input  logic [1:0]         mask_i,      // bit 0 ex read, bit 1 clint read ignored
    input  csr_pkg::csr_word_t exp_ex_rdata_i,
    input  csr_pkg::csr_word_t exp_clint_rdata_i,
    input  logic               exp_gie_i,
    input  csr_pkg::csr_word_t ex_rdata_i,
    input  csr_pkg::csr_word_t clint_rdata_i,
    input  logic               global_int_en_i,
    input  csr_pkg::csr_word_t clint_mtvec_i,
    input  csr_pkg::csr_word_t clint_mepc_i,
    input  csr_pkg::csr_word_t clint_mstatus_i,
    input  csr_pkg::csr_word_t clint_mie_i,
    output logic               done_o,
    output int                 error_count_o,
    output int                 check_count_o
);
    import csr_pkg::*;

    int   err_total = 0;
    int   check_total = 0;
    int   cur_test = 0;
    int   test_vecs = 0;
    int   test_errs = 0;
    logic in_test = 1'b0;
    logic finished = 1'b0;

    task automatic compare_word(input string name, input csr_word_t got, input csr_word_t exp);
        check_total++;
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h (vector %0d)",
                     name, got, exp, vec_idx_i);
            err_total++;
            test_errs++;
        end
    endtask

    task automatic report_test();
        $display("test %0d: %0d vectors, %0d errors", cur_test, test_vecs, test_errs);
    endtask

    // values seen here are the ones just before the edge
    always @(posedge clk_i) begin
        if (vec_valid_i) begin
            if (in_test && test_id_i != cur_test) begin
                report_test();
            end
            if (!in_test || test_id_i != cur_test) begin
                cur_test  = test_id_i;
                test_vecs = 0;
                test_errs = 0;
                in_test   = 1'b1;
            end
            test_vecs++;
            if (!mask_i[0]) begin
                compare_word("ex_rdata_o", ex_rdata_i, exp_ex_rdata_i);
            end
            if (!mask_i[1]) begin
                compare_word("clint_rdata_o", clint_rdata_i, exp_clint_rdata_i);
                // exported trap state matches a plain clint read
                if (!(clint_we_i && clint_waddr_i == clint_raddr_i)) begin
                    case (clint_raddr_i)
                        CSR_MSTATUS: compare_word("clint_mstatus_o", clint_mstatus_i,
                                                  exp_clint_rdata_i);
                        CSR_MIE:     compare_word("clint_mie_o", clint_mie_i, exp_clint_rdata_i);
                        CSR_MTVEC:   compare_word("clint_mtvec_o", clint_mtvec_i,
                                                  exp_clint_rdata_i);
                        CSR_MEPC:    compare_word("clint_mepc_o", clint_mepc_i, exp_clint_rdata_i);
                        default:     ;
                    endcase
                end
            end
            compare_word("global_int_en_o", csr_word_t'(global_int_en_i), csr_word_t'(exp_gie_i));
        end else if (in_test) begin
            report_test(); // last test closes when the vectors stop
            in_test = 1'b0;
            finished <= 1'b1;
        end
    end

    assign done_o        = finished;
    assign error_count_o = err_total;
    assign check_count_o = check_total;

endmodule

//--- verilog/csr_top.sv
/*
 * Machine-mode CSR block.
 * Two access ports, ex and clint, sharing the trap registers and
 * the mcycle/minstret counters. ex wins on a same-address write.
 * Exports the global interrupt enable and the trap state to clint.
 */
`timescale 1ns/100ps

module csr_top #(
    parameter csr_pkg::csr_word_t MISA_VALUE  = 32'h4000_1100,
    parameter csr_pkg::csr_word_t MTVEC_RESET = '0
) (
    input  logic                clk,
    input  logic                reset_i,
    // ex port
    input  logic                ex_we_i,
    input  csr_pkg::csr_addr_t  ex_waddr_i,
    input  csr_pkg::csr_word_t  ex_wdata_i,
    input  csr_pkg::csr_addr_t  ex_raddr_i,
    output csr_pkg::csr_word_t  ex_rdata_o,
    // clint port
    input  logic                clint_we_i,
    input  csr_pkg::csr_addr_t  clint_waddr_i,
    input  csr_pkg::csr_word_t  clint_wdata_i,
    input  csr_pkg::csr_addr_t  clint_raddr_i,
    output csr_pkg::csr_word_t  clint_rdata_o,
    input  logic                inst_valid_i,   // retired instruction
    output logic                global_int_en_o,
    output csr_pkg::csr_word_t  clint_mtvec_o,
    output csr_pkg::csr_word_t  clint_mepc_o,
    output csr_pkg::csr_word_t  clint_mstatus_o,
    output csr_pkg::csr_word_t  clint_mie_o
);
    import csr_pkg::*;

    csr_port_if ex_port ();
    csr_port_if clint_port ();

    logic [NUM_TRAP-1:0]                trap_we;
    csr_word_t [NUM_TRAP-1:0]           trap_wdata;
    csr_word_t [NUM_TRAP-1:0]           trap_q;
    logic [NUM_CNT-1:0]                 cnt_we;
    csr_word_t [NUM_CNT-1:0]            cnt_wdata;
    csr_dword_t                         mcycle_q, minstret_q;

    assign ex_port.we       = ex_we_i;
    assign ex_port.waddr    = ex_waddr_i;
    assign ex_port.wdata    = ex_wdata_i;
    assign ex_port.raddr    = ex_raddr_i;
    assign ex_rdata_o       = ex_port.rdata;

    assign clint_port.we    = clint_we_i;
    assign clint_port.waddr = clint_waddr_i;
    assign clint_port.wdata = clint_wdata_i;
    assign clint_port.raddr = clint_raddr_i;
    assign clint_rdata_o    = clint_port.rdata;

    csr_write_arbiter i_csr_write_arbiter (
        .ex           (ex_port),
        .clint        (clint_port),
        .trap_we_o    (trap_we),
        .trap_wdata_o (trap_wdata),
        .cnt_we_o     (cnt_we),
        .cnt_wdata_o  (cnt_wdata)
    );

    csr_trap_regs #(
        .MTVEC_RESET (MTVEC_RESET)
    ) i_csr_trap_regs (
        .clk             (clk),
        .reset_i         (reset_i),
        .trap_we_i       (trap_we),
        .trap_wdata_i    (trap_wdata),
        .trap_q_o        (trap_q),
        .global_int_en_o (global_int_en_o),
        .mtvec_o         (clint_mtvec_o),
        .mepc_o          (clint_mepc_o),
        .mstatus_o       (clint_mstatus_o),
        .mie_o           (clint_mie_o)
    );

    csr_counters i_csr_counters (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .cnt_we_i     (cnt_we),
        .cnt_wdata_i  (cnt_wdata),
        .mcycle_o     (mcycle_q),
        .minstret_o   (minstret_q)
    );

    csr_read_mux #(
        .MISA_VALUE (MISA_VALUE)
    ) i_ex_read_mux (
        .port       (ex_port),
        .trap_q_i   (trap_q),
        .mcycle_i   (mcycle_q),
        .minstret_i (minstret_q)
    );

    csr_read_mux #(
        .MISA_VALUE (MISA_VALUE)
    ) i_clint_read_mux (
        .port       (clint_port),
        .trap_q_i   (trap_q),
        .mcycle_i   (mcycle_q),
        .minstret_i (minstret_q)
    );

endmodule

//--- verilog/csr_read_mux.sv
/*
 * CSR read select for one access port.
 * Same-port write data is bypassed to the read when the addresses
 * match. Otherwise picks a trap register, a counter half or misa;
 * anything else reads zero.
 */
`timescale 1ns/100ps

module csr_read_mux #(
    parameter csr_pkg::csr_word_t MISA_VALUE = 32'h4000_1100 // RV32IM
) (
    csr_port_if.rd                                          port,
    input  csr_pkg::csr_word_t [csr_pkg::NUM_TRAP-1:0] trap_q_i,
    input  csr_pkg::csr_dword_t                             mcycle_i,
    input  csr_pkg::csr_dword_t                             minstret_i
);
    import csr_pkg::*;

    csr_word_t rd_data;
    logic      bypass;

    assign bypass = port.we && (port.waddr == port.raddr);

    always_comb begin
        if (bypass) begin
            rd_data = port.wdata; // own write seen in the same cycle
        end else begin
            case (port.raddr)
                CSR_MSTATUS:   rd_data = trap_q_i[MSTATUS];
                CSR_MIE:       rd_data = trap_q_i[MIE];
                CSR_MTVEC:     rd_data = trap_q_i[MTVEC];
                CSR_MSCRATCH:  rd_data = trap_q_i[MSCRATCH];
                CSR_MEPC:      rd_data = trap_q_i[MEPC];
                CSR_MCAUSE:    rd_data = trap_q_i[MCAUSE];
                CSR_MISA:      rd_data = MISA_VALUE;
                CSR_MCYCLE:    rd_data = mcycle_i[31:0];
                CSR_MCYCLEH:   rd_data = mcycle_i[63:32];
                CSR_MINSTRET:  rd_data = minstret_i[31:0];
                CSR_MINSTRETH: rd_data = minstret_i[63:32];
                default:       rd_data = '0;
            endcase
        end
    end

    assign port.rdata = rd_data;

endmodule

//--- verilog/csr_counters.sv
/*
 * mcycle and minstret.
 * Two 64-bit counters, writable by 32-bit halves. A write on an
 * edge replaces the count for that edge; mcycle counts every
 * cycle, minstret only retired instructions.
 */
`timescale 1ns/100ps

module csr_counters (
    input  logic                                           clk,
    input  logic                                           reset_i,
    input  logic                                           inst_valid_i,
    input  logic [csr_pkg::NUM_CNT-1:0]                    cnt_we_i,
    input  csr_pkg::csr_word_t [csr_pkg::NUM_CNT-1:0] cnt_wdata_i,
    output csr_pkg::csr_dword_t                            mcycle_o,
    output csr_pkg::csr_dword_t                            minstret_o
);
    import csr_pkg::*;

    // next count of one counter where half writes beat counting
    function automatic csr_dword_t cnt_next(
        input csr_dword_t q,
        input logic       inc,
        input logic       we_lo,
        input logic       we_hi,
        input csr_word_t  wdata_lo,
        input csr_word_t  wdata_hi
    );
        csr_dword_t d;
        d = q + csr_dword_t'(inc);
        if (we_lo || we_hi) begin
            d = q;
            if (we_lo) d[31:0] = wdata_lo;
            if (we_hi) d[63:32] = wdata_hi;
        end
        return d;
    endfunction

    csr_dword_t mcycle_d, minstret_d;

    always_comb begin
        mcycle_d   = cnt_next(mcycle_o, 1'b1,
                              cnt_we_i[MCYCLE_LO], cnt_we_i[MCYCLE_HI],
                              cnt_wdata_i[MCYCLE_LO], cnt_wdata_i[MCYCLE_HI]);
        minstret_d = cnt_next(minstret_o, inst_valid_i,
                              cnt_we_i[MINSTRET_LO], cnt_we_i[MINSTRET_HI],
                              cnt_wdata_i[MINSTRET_LO], cnt_wdata_i[MINSTRET_HI]);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
        end else begin
            mcycle_o   <= mcycle_d;
            minstret_o <= minstret_d;
        end
    end

endmodule

//--- verilog/csr_trap_regs.sv
/*
 * Machine trap registers.
 * mstatus, mie, mtvec, mscratch, mepc and mcause with load enables.
 * Also drives the global interrupt enable and the values the
 * interrupt controller consumes.
 */
`timescale 1ns/100ps

module csr_trap_regs #(
    parameter csr_pkg::csr_word_t MTVEC_RESET = '0
) (
    input  logic                                            clk,
    input  logic                                            reset_i,
    input  logic [csr_pkg::NUM_TRAP-1:0]                    trap_we_i,
    input  csr_pkg::csr_word_t [csr_pkg::NUM_TRAP-1:0] trap_wdata_i,
    output csr_pkg::csr_word_t [csr_pkg::NUM_TRAP-1:0] trap_q_o,
    output logic                                            global_int_en_o,
    output csr_pkg::csr_word_t                              mtvec_o,
    output csr_pkg::csr_word_t                              mepc_o,
    output csr_pkg::csr_word_t                              mstatus_o,
    output csr_pkg::csr_word_t                              mie_o
);
    import csr_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            trap_q_o        <= '0;
            trap_q_o[MTVEC] <= MTVEC_RESET; // trap vector comes up at its boot value
        end else begin
            for (int i = 0; i < NUM_TRAP; i++) begin
                if (trap_we_i[i]) begin
                    trap_q_o[i] <= trap_wdata_i[i];
                end
            end
        end
    end

    assign global_int_en_o = trap_q_o[MSTATUS][MSTATUS_MIE_BIT];

    // to clint
    assign mtvec_o   = trap_q_o[MTVEC];
    assign mepc_o    = trap_q_o[MEPC];
    assign mstatus_o = trap_q_o[MSTATUS];
    assign mie_o     = trap_q_o[MIE];

endmodule

//--- verilog/csr_write_arbiter.sv
/*
 * CSR write arbiter.
 * Decodes the ex and clint write ports into per-register strobes
 * and data. Both ports may write in the same cycle; on the same
 * address the ex port wins.
 */
`timescale 1ns/100ps

module csr_write_arbiter (
    csr_port_if.arb ex,
    csr_port_if.arb clint,
    output logic [csr_pkg::NUM_TRAP-1:0]                    trap_we_o,
    output csr_pkg::csr_word_t [csr_pkg::NUM_TRAP-1:0] trap_wdata_o,
    output logic [csr_pkg::NUM_CNT-1:0]                     cnt_we_o,
    output csr_pkg::csr_word_t [csr_pkg::NUM_CNT-1:0]  cnt_wdata_o
);
    import csr_pkg::*;

    function automatic logic [NUM_CNT-1:0] cnt_onehot(input csr_addr_t addr);
        logic [NUM_CNT-1:0] oh;
        oh = '0;
        case (addr)
            CSR_MCYCLE:    oh[MCYCLE_LO]   = 1'b1;
            CSR_MCYCLEH:   oh[MCYCLE_HI]   = 1'b1;
            CSR_MINSTRET:  oh[MINSTRET_LO] = 1'b1;
            CSR_MINSTRETH: oh[MINSTRET_HI] = 1'b1;
            default:       oh = '0;
        endcase
        return oh;
    endfunction

    trap_idx_e           ex_trap_idx, clint_trap_idx;
    logic                ex_trap_hit, clint_trap_hit;
    logic [NUM_TRAP-1:0] ex_trap_oh, clint_trap_oh;
    logic [NUM_CNT-1:0]  ex_cnt_oh, clint_cnt_oh;

    // decode each port once
    always_comb begin
        ex_trap_hit    = ex.we & trap_decode(ex.waddr, ex_trap_idx);
        clint_trap_hit = clint.we & trap_decode(clint.waddr, clint_trap_idx);
        ex_trap_oh     = '0;
        clint_trap_oh  = '0;
        if (ex_trap_hit) ex_trap_oh[ex_trap_idx] = 1'b1;
        if (clint_trap_hit) clint_trap_oh[clint_trap_idx] = 1'b1;
        ex_cnt_oh    = ex.we ? cnt_onehot(ex.waddr) : '0;
        clint_cnt_oh = clint.we ? cnt_onehot(clint.waddr) : '0;
    end

    always_comb begin
        trap_we_o = ex_trap_oh | clint_trap_oh;
        cnt_we_o  = ex_cnt_oh | clint_cnt_oh;
        for (int i = 0; i < NUM_TRAP; i++) begin
            trap_wdata_o[i] = ex_trap_oh[i] ? ex.wdata : clint.wdata; // ex first
        end
        for (int i = 0; i < NUM_CNT; i++) begin
            cnt_wdata_o[i] = ex_cnt_oh[i] ? ex.wdata : clint.wdata;
        end
    end

endmodule

//--- verilog/csr_port_if.sv
/*
 * One CSR access port.
 * Write strobe, write address and data, read address and the
 * combinational read data returned to the requester.
 */
`timescale 1ns/100ps

interface csr_port_if;
    import csr_pkg::*;

    logic      we;
    csr_addr_t waddr;
    csr_word_t wdata;
    csr_addr_t raddr;
    csr_word_t rdata;

    // write side only
    modport arb (input we, waddr, wdata);

    // read side sees the write fields for the bypass
    modport rd (input we, waddr, wdata, raddr, output rdata);

endinterface

//--- verilog/csr_pkg.sv
/*
 * Machine-mode CSR definitions.
 * Word and address types, the CSR addresses kept by this block,
 * register indices and the trap register address decode.
 */
package csr_pkg;

    typedef logic [31:0] csr_word_t;
    typedef logic [63:0] csr_dword_t;
    typedef logic [11:0] csr_addr_t;

    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MCYCLE    = 12'hb00;
    localparam csr_addr_t CSR_MINSTRET  = 12'hb02;
    localparam csr_addr_t CSR_MCYCLEH   = 12'hb80;
    localparam csr_addr_t CSR_MINSTRETH = 12'hb82;

    localparam int NUM_TRAP = 6;
    localparam int NUM_CNT  = 4;

    localparam int MSTATUS_MIE_BIT = 3; // global interrupt enable

    typedef enum logic [2:0] {
        MSTATUS  = 3'd0,
        MIE      = 3'd1,
        MTVEC    = 3'd2,
        MSCRATCH = 3'd3,
        MEPC     = 3'd4,
        MCAUSE   = 3'd5
    } trap_idx_e;

    typedef enum logic [1:0] {
        MCYCLE_LO   = 2'd0,
        MCYCLE_HI   = 2'd1,
        MINSTRET_LO = 2'd2,
        MINSTRET_HI = 2'd3
    } cnt_idx_e;

    // returns 1 when addr is one of the six trap registers
    function automatic logic trap_decode(input csr_addr_t addr, output trap_idx_e idx);
        logic hit;
        hit = 1'b1;
        idx = MSTATUS;
        case (addr)
            CSR_MSTATUS:  idx = MSTATUS;
            CSR_MIE:      idx = MIE;
            CSR_MTVEC:    idx = MTVEC;
            CSR_MSCRATCH: idx = MSCRATCH;
            CSR_MEPC:     idx = MEPC;
            CSR_MCAUSE:   idx = MCAUSE;
            default:      hit = 1'b0;
        endcase
        return hit;
    endfunction

endpackage
